// File: hdl/dmem_config.svh
`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

// byte address width, 12 bits gives 4 KiB
`define DMEM_ADDR_W 12

// number of 32-bit words behind that address space
`define DMEM_WORDS ((1 << `DMEM_ADDR_W) / 4)

// word index drops the two byte offset bits
// so index width is `DMEM_ADDR_W - 2 everywhere

`endif

// File: hdl/dmem_pkg.sv
package dmem_pkg;

    // funct3 codes for loads and stores
    // stores only use B, H and W
    typedef enum logic [2:0] {
        LSU_B  = 3'b000, // lb / sb
        LSU_H  = 3'b001, // lh / sh
        LSU_W  = 3'b010, // lw / sw
        LSU_BU = 3'b100, // lbu
        LSU_HU = 3'b101  // lhu
    } lsu_op_e;

    // one memory word seen two ways
    // lane[0] is the byte at offset 0 (little endian)
    typedef union packed {
        logic [31:0]      word; // whole word view
        logic [3:0][7:0]  lane; // per byte lane view
    } dmem_word_u;

endpackage

// File: hdl/dmem_req_if.sv
`timescale 1ns/1ns
`include "dmem_config.svh"

// decoded request, combinational from decode to the array
interface dmem_req_if;
    import dmem_pkg::*;

    logic                    valid;    // cyc && stb
    logic                    we;       // store when high
    logic                    err;      // misaligned or illegal funct3
    logic [`DMEM_ADDR_W-3:0] word_idx; // address without byte offset
    logic [3:0]              byte_en;  // lanes to write, zero for loads
    dmem_word_u              wdata;    // store data already in its lanes
    lsu_op_e                 op;       // funct3 of the access
    logic [1:0]              byte_off; // low address bits

    // decode side
    modport producer (
        output valid, we, err, word_idx, byte_en, wdata, op, byte_off
    );

    // array side
    modport consumer (
        input valid, we, err, word_idx, byte_en, wdata, op, byte_off
    );

endinterface

// File: hdl/dmem_access_decode.sv
`timescale 1ns/1ns
`include "dmem_config.svh"

module dmem_access_decode (
    input  logic [`DMEM_ADDR_W-1:0] wb_adr_i,
    input  logic [31:0]             wb_dat_i,
    input  logic                    wb_we_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_cyc_i,
    input  dmem_pkg::lsu_op_e       wb_funct3_i,
    dmem_req_if.producer            req_o
);
    import dmem_pkg::*;

    logic [2:0] f3;       // raw funct3, may hold codes outside the enum
    logic [1:0] off;
    logic       misalign;
    logic       illegal;

    assign f3  = wb_funct3_i;
    assign off = wb_adr_i[1:0];

    // address split
    assign req_o.valid    = wb_cyc_i & wb_stb_i;
    assign req_o.we       = wb_we_i;
    assign req_o.word_idx = wb_adr_i[`DMEM_ADDR_W-1:2];
    assign req_o.byte_off = off;
    assign req_o.op       = wb_funct3_i;
    assign req_o.err      = misalign | illegal;

    always_comb begin
        case (f3)
            LSU_H, LSU_HU: misalign = off[0]; // halfword on odd byte
            LSU_W:         misalign = |off;   // word must sit on offset 0
            default:       misalign = 1'b0;
        endcase
    end

    always_comb begin
        if (wb_we_i) begin
            illegal = (f3 > 3'd2); // no unsigned or wider stores
        end else begin
            illegal = (f3 == 3'd3) || (f3 == 3'd6) || (f3 == 3'd7);
        end
    end

    // lane steering for stores
    always_comb begin
        req_o.byte_en    = 4'b0000;
        req_o.wdata.word = wb_dat_i; // sw and default
        case (f3)
            LSU_B: begin
                req_o.byte_en    = 4'b0001 << off;
                req_o.wdata.lane = {4{wb_dat_i[7:0]}}; // byte in every lane
            end
            LSU_H: begin
                req_o.byte_en          = 4'b0011 << off;
                req_o.wdata.lane[1:0]  = wb_dat_i[15:0];
                req_o.wdata.lane[3:2]  = wb_dat_i[15:0]; // upper half copy
            end
            LSU_W: begin
                req_o.byte_en = 4'b1111;
            end
            default: begin
                req_o.byte_en = 4'b0000;
            end
        endcase
        // loads and refused stores touch nothing
        if (!wb_we_i || misalign || illegal) begin
            req_o.byte_en = 4'b0000;
        end
    end

endmodule

// File: hdl/dmem_byte_array.sv
`timescale 1ns/1ns
`include "dmem_config.svh"

module dmem_byte_array (
    input  logic                 clk,
    input  logic                 rst,
    dmem_req_if.consumer         req_i,
    output dmem_pkg::dmem_word_u rdata_o,
    output dmem_pkg::lsu_op_e    rd_op_o,
    output logic [1:0]           rd_off_o,
    output logic                 ack_o,
    output logic                 err_o
);
    import dmem_pkg::*;

    dmem_word_u mem [`DMEM_WORDS]; // four byte lanes per word

    logic busy;   // answer on the bus this cycle
    logic accept; // request taken this edge
    logic legal;  // taken and not flagged

    assign busy   = ack_o | err_o;
    assign accept = req_i.valid & ~busy; // no back to back answers
    assign legal  = accept & ~req_i.err;

    // handshake and load bookkeeping
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_o    <= 1'b0;
            err_o    <= 1'b0;
            rd_op_o  <= LSU_B;
            rd_off_o <= 2'b00;
        end else begin
            ack_o <= legal;
            err_o <= accept & req_i.err;
            if (legal && !req_i.we) begin
                rd_op_o  <= req_i.op;       // kept for result stage
                rd_off_o <= req_i.byte_off;
            end
        end
    end

    // storage, write first then registered read
    always_ff @(posedge clk) begin
        if (legal) begin
            if (req_i.we) begin
                for (int l = 0; l < 4; l++) begin
                    if (req_i.byte_en[l]) begin
                        mem[req_i.word_idx].lane[l] <= req_i.wdata.lane[l];
                    end
                end
            end else begin
                rdata_o.word <= mem[req_i.word_idx].word; // whole word, align later
            end
        end
    end

endmodule

// File: hdl/dmem_load_align.sv
`timescale 1ns/1ns

module dmem_load_align (
    input  dmem_pkg::dmem_word_u rdata_i,
    input  dmem_pkg::lsu_op_e    rd_op_i,
    input  logic [1:0]           rd_off_i,
    output logic [31:0]          data_o
);
    import dmem_pkg::*;

    logic [7:0]  sel_b; // addressed byte
    logic [15:0] sel_h; // addressed halfword

    assign sel_b = rdata_i.lane[rd_off_i];

    // offset bit 0 is always clear for legal halfword loads
    assign sel_h = rd_off_i[1] ? rdata_i.lane[3:2] : rdata_i.lane[1:0];

    always_comb begin
        case (rd_op_i)
            LSU_B: begin
                data_o = {{24{sel_b[7]}}, sel_b}; // sign extend
            end
            LSU_BU: begin
                data_o = {24'h000000, sel_b};
            end
            LSU_H: begin
                data_o = {{16{sel_h[15]}}, sel_h};
            end
            LSU_HU: begin
                data_o = {16'h0000, sel_h};
            end
            default: begin
                data_o = rdata_i.word; // lw passes through
            end
        endcase
    end

endmodule

// File: hdl/dmem_wb_top.sv
`timescale 1ns/1ns
`include "dmem_config.svh"

module dmem_wb_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`DMEM_ADDR_W-1:0] wb_adr_i,    // byte address
    input  logic [31:0]             wb_dat_i,
    input  logic                    wb_we_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_cyc_i,
    input  dmem_pkg::lsu_op_e       wb_funct3_i, // access width and sign
    output logic [31:0]             wb_dat_o,    // valid during ack
    output logic                    wb_ack_o,
    output logic                    wb_err_o
);
    import dmem_pkg::*;

    dmem_req_if req ();   // decode to array

    dmem_word_u rdata;    // raw word from the array
    lsu_op_e    rd_op;
    logic [1:0] rd_off;

    dmem_access_decode dmem_access_decode_i (
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_we_i     (wb_we_i),
        .wb_stb_i    (wb_stb_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_funct3_i (wb_funct3_i),
        .req_o       (req.producer)
    );

    dmem_byte_array dmem_byte_array_i (
        .clk      (clk),
        .rst      (rst),
        .req_i    (req.consumer),
        .rdata_o  (rdata),
        .rd_op_o  (rd_op),
        .rd_off_o (rd_off),
        .ack_o    (wb_ack_o),
        .err_o    (wb_err_o)
    );

    // result stage straight onto the bus
    dmem_load_align dmem_load_align_i (
        .rdata_i  (rdata),
        .rd_op_i  (rd_op),
        .rd_off_i (rd_off),
        .data_o   (wb_dat_o)
    );

endmodule

// File: tests/tb_clkgen.sv
`timescale 1ns/1ns

// free running testbench clock
module tb_clkgen (
    output logic clk_o
);
    localparam int HALF = 50; // 100 ns period

    initial begin
        clk_o = 1'b0;
    end

    always #HALF clk_o = ~clk_o;

endmodule

// File: tests/dmem_wb_chk.sv
`timescale 1ns/1ns

// bus handshake properties, attached to the top level
module dmem_wb_chk (
    input logic clk_i,
    input logic rst_i,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic err_i
);
    int   fail_cnt = 0; // watched from the testbench
    logic answer;

    assign answer = ack_i | err_i;

    // one kind of answer at a time
    no_double: assert property (@(posedge clk_i) disable iff (rst_i) !(ack_i && err_i))
        else begin
            fail_cnt++;
            $error("ack and err high in the same cycle");
        end

    // answer only follows a sampled request
    after_req: assert property (@(posedge clk_i) disable iff (rst_i)
        answer |-> $past(cyc_i && stb_i))
        else begin
            fail_cnt++;
            $error("answer without a request in the previous cycle");
        end

    // never two answer cycles in a row
    one_shot: assert property (@(posedge clk_i) disable iff (rst_i) answer |=> !answer)
        else begin
            fail_cnt++;
            $error("answer held for two cycles");
        end

    // quiet bus in reset
    rst_quiet: assert property (@(posedge clk_i) rst_i |-> !answer)
        else begin
            fail_cnt++;
            $error("answer while reset is high");
        end

endmodule

bind dmem_wb_top dmem_wb_chk dmem_wb_chk_i (
    .clk_i (clk),
    .rst_i (rst),
    .cyc_i (wb_cyc_i),
    .stb_i (wb_stb_i),
    .ack_i (wb_ack_o),
    .err_i (wb_err_o)
);

// File: tests/dmem_wb_tb.sv
`timescale 1ns/1ns
`include "dmem_config.svh"

module dmem_wb_tb;
    import dmem_pkg::*;

    localparam int ADDR_W  = `DMEM_ADDR_W;
    localparam int N_WORDS = `DMEM_WORDS;
    localparam int PERIOD  = 100;
    localparam int DLY     = 10;   // drive and sample point after the edge
    // transactions of all tests together
    localparam int MAX_TXN = 2 * N_WORDS + 16 * 24 + 8 * 11 + 8 * 9 + 300 + 2;

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] adr;
    logic [31:0]       wdat;
    logic              we;
    logic              stb;
    logic              cyc;
    lsu_op_e           funct3;
    logic [31:0]       rdat;
    logic              ack;
    logic              err;

    integer            seed = 32'hb833;
    logic [7:0]        model [0:N_WORDS*4-1]; // byte image of the memory
    bit                exp_err_q [$];         // expected answers in bus order
    bit                exp_load_q [$];
    logic [31:0]       exp_data_q [$];
    bit                e_err;
    bit                e_load;
    logic [31:0]       e_data;

    tb_clkgen tb_clkgen_i (
        .clk_o (clk)
    );

    dmem_wb_top dmem_wb_top_i (
        .clk         (clk),
        .rst         (rst),
        .wb_adr_i    (adr),
        .wb_dat_i    (wdat),
        .wb_we_i     (we),
        .wb_stb_i    (stb),
        .wb_cyc_i    (cyc),
        .wb_funct3_i (funct3),
        .wb_dat_o    (rdat),
        .wb_ack_o    (ack),
        .wb_err_o    (err)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s expected 0x%h got 0x%h",
                                $time, name, exp, act));
        end
    endtask

    // funct3 legality and natural alignment
    function automatic bit refused(input bit is_st, input logic [2:0] f3,
                                   input logic [ADDR_W-1:0] a);
        bit ok;
        int size;
        case (f3)
            3'd0, 3'd1, 3'd2: ok = 1'b1;
            3'd4, 3'd5:       ok = !is_st; // unsigned forms are loads only
            default:          ok = 1'b0;
        endcase
        size = 1 << f3[1:0];
        return !ok || (a % size != 0);
    endfunction

    function automatic void store_model(input logic [2:0] f3, input logic [ADDR_W-1:0] a,
                                        input logic [31:0] d);
        int i;
        for (i = 0; i < (1 << f3[1:0]); i++) begin
            model[a + i] = d[8*i +: 8]; // little endian bytes
        end
    endfunction

    function automatic logic [31:0] expected_load(input logic [ADDR_W-1:0] a,
                                                  input logic [2:0] f3);
        logic [31:0] raw;
        int          i;
        int          size;
        raw  = 32'h0;
        size = 1 << f3[1:0];
        for (i = 0; i < size; i++) begin
            raw[8*i +: 8] = model[a + i];
        end
        if (!f3[2] && size == 1) raw = {{24{raw[7]}}, raw[7:0]};    // lb
        if (!f3[2] && size == 2) raw = {{16{raw[15]}}, raw[15:0]};  // lh
        return raw;
    endfunction

    // queue the expected answer and update the model on a good store
    function automatic void expect_answer(input bit is_st, input logic [2:0] f3,
                                          input logic [ADDR_W-1:0] a, input logic [31:0] d);
        bit bad;
        bad = refused(is_st, f3, a);
        exp_err_q.push_back(bad);
        exp_load_q.push_back(!is_st);
        exp_data_q.push_back((is_st || bad) ? 32'h0 : expected_load(a, f3));
        if (is_st && !bad) store_model(f3, a, d);
    endfunction

    task automatic drive_req(input bit is_st, input logic [2:0] f3,
                             input logic [ADDR_W-1:0] a, input logic [31:0] d);
        adr    = a;
        wdat   = d;
        we     = is_st;
        funct3 = lsu_op_e'(f3); // illegal codes pass through the cast
        cyc    = 1'b1;
        stb    = 1'b1;
    endtask

    // issue one request and wait for ack or err
    task automatic do_access(input bit is_st, input logic [2:0] f3,
                             input logic [ADDR_W-1:0] a, input logic [31:0] d);
        int waited;
        expect_answer(is_st, f3, a, d);
        @(posedge clk);
        #DLY;
        drive_req(is_st, f3, a, d);
        waited = 0;
        do begin
            @(posedge clk);
            #DLY;
            waited++;
        end while (!(ack || err) && waited < 4);
        if (!(ack || err)) abort_run("no ack or err within 4 cycles of a request");
        check_val("answer latency", 32'd1, waited);
        cyc = 1'b0; // stb drops after the answer
        stb = 1'b0;
    endtask

    // compare every answer against the queue
    always begin
        @(posedge clk);
        #DLY;
        if (ack || err) begin
            if (exp_err_q.size() == 0) begin
                abort_run("answer on the bus with no request outstanding");
            end else begin
                e_err  = exp_err_q.pop_front();
                e_load = exp_load_q.pop_front();
                e_data = exp_data_q.pop_front();
                check_val("wb_err_o", e_err, err);
                check_val("wb_ack_o", !e_err, ack);
                if (e_load && !e_err) check_val("wb_dat_o", e_data, rdat);
            end
        end
    end

    // handshake assertion failures from the bound checker
    always @(dmem_wb_top_i.dmem_wb_chk_i.fail_cnt) begin
        if (dmem_wb_top_i.dmem_wb_chk_i.fail_cnt != 0) begin
            abort_run("bus handshake assertion failed");
        end
    end

    initial begin
        #(MAX_TXN * 4 * PERIOD + 200 * PERIOD);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        int                w;
        int                k;
        bit                r_we;
        logic [2:0]        r_f3;
        logic [ADDR_W-1:0] r_adr;
        logic [ADDR_W-1:0] base;
        rst    = 1'b1;
        adr    = '0;
        wdat   = 32'h0;
        we     = 1'b0;
        stb    = 1'b1; // lw held through reset gets no answer
        cyc    = 1'b1;
        funct3 = LSU_W;
        repeat (2) @(posedge clk);
        #DLY;
        rst = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        repeat (3) begin // idle bus stays silent
            @(posedge clk);
            #DLY;
            check_val("wb_ack_o", 32'h0, ack);
            check_val("wb_err_o", 32'h0, err);
        end
        // word round trip over the whole array
        for (w = 0; w < N_WORDS; w++) do_access(1'b1, 3'd2, ADDR_W'(w << 2), $random(seed));
        for (w = 0; w < N_WORDS; w++) do_access(1'b0, 3'd2, ADDR_W'(w << 2), 32'h0);
        // sb and sh at every legal offset followed by all load forms
        for (w = 0; w < 16; w++) begin
            base = ADDR_W'(($random(seed) & (N_WORDS - 1)) << 2);
            for (k = 0; k < 4; k++) begin
                do_access(1'b1, 3'd0, base + ADDR_W'(k), $random(seed));
                do_access(1'b0, 3'd2, base, 32'h0);
                do_access(1'b0, 3'd0, base + ADDR_W'(k), 32'h0);
                do_access(1'b0, 3'd4, base + ADDR_W'(k), 32'h0);
            end
            for (k = 0; k < 4; k += 2) begin
                do_access(1'b1, 3'd1, base + ADDR_W'(k), $random(seed));
                do_access(1'b0, 3'd2, base, 32'h0);
                do_access(1'b0, 3'd1, base + ADDR_W'(k), 32'h0);
                do_access(1'b0, 3'd5, base + ADDR_W'(k), 32'h0);
            end
        end
        // misaligned halfword and word accesses
        for (w = 0; w < 8; w++) begin
            base = ADDR_W'(($random(seed) & (N_WORDS - 1)) << 2);
            for (k = 1; k < 4; k += 2) begin
                do_access(1'b0, 3'd1, base + ADDR_W'(k), 32'h0);
                do_access(1'b1, 3'd1, base + ADDR_W'(k), $random(seed));
            end
            for (k = 1; k < 4; k++) begin
                do_access(1'b0, 3'd2, base + ADDR_W'(k), 32'h0);
                do_access(1'b1, 3'd2, base + ADDR_W'(k), $random(seed));
            end
            do_access(1'b0, 3'd2, base, 32'h0); // word must be untouched
        end
        // illegal funct3 codes
        for (w = 0; w < 8; w++) begin
            base = ADDR_W'(($random(seed) & (N_WORDS - 1)) << 2);
            for (k = 3; k < 8; k++) do_access(1'b1, 3'(k), base, $random(seed));
            do_access(1'b0, 3'd3, base, 32'h0);
            do_access(1'b0, 3'd6, base, 32'h0);
            do_access(1'b0, 3'd7, base, 32'h0);
            do_access(1'b0, 3'd2, base, 32'h0);
        end
        // random mix
        for (w = 0; w < 300; w++) begin
            r_we  = $random(seed);
            r_f3  = $random(seed);
            r_adr = $random(seed);
            do_access(r_we, r_f3, r_adr, $random(seed));
        end
        // held request gives answer then gap then answer
        expect_answer(1'b0, 3'd2, '0, 32'h0);
        expect_answer(1'b0, 3'd2, '0, 32'h0);
        @(posedge clk);
        #DLY;
        drive_req(1'b0, 3'd2, '0, 32'h0);
        for (k = 0; k < 3; k++) begin
            @(posedge clk);
            #DLY;
            check_val("wb_ack_o", 32'(k != 1), ack);
        end
        cyc = 1'b0;
        stb = 1'b0;
        @(posedge clk);
        #DLY;
        if (exp_err_q.size() != 0) begin
            abort_run("expected answers never arrived");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: dmem_wb_top.f
+incdir+hdl
hdl/dmem_pkg.sv
hdl/dmem_req_if.sv
hdl/dmem_access_decode.sv
hdl/dmem_byte_array.sv
hdl/dmem_load_align.sv
hdl/dmem_wb_top.sv
tests/tb_clkgen.sv
tests/dmem_wb_chk.sv
tests/dmem_wb_tb.sv

// File: Bender.yml
package:
  name: dmem_wb

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dmem_pkg.sv
      - hdl/dmem_req_if.sv
      - hdl/dmem_access_decode.sv
      - hdl/dmem_byte_array.sv
      - hdl/dmem_load_align.sv
      - hdl/dmem_wb_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_clkgen.sv
      - tests/dmem_wb_chk.sv
      - tests/dmem_wb_tb.sv
